/* project.f */
rtl/qsim_pkg.sv
rtl/qsim_ctrl.sv
rtl/qsim_index_counter.sv
rtl/qsim_state_buffer.sv
rtl/qsim_cmac.sv
rtl/qsim_top.sv
bench/tb_clock.sv
bench/qsim_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the qsim testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -j 0 -Wno-fatal --timescale 1ns/100ps \
    --top-module qsim_tb -f project.f; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vqsim_tb > sim.log 2>&1
sim_status=$?
cat sim.log

if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

# Verdict comes from the log
if grep -qx "Done: no errors" sim.log; then
  exit 0
fi
exit 1

/* bench/qsim_tb.sv */
`default_nettype none
`timescale 1ns/100ps

module qsim_tb;

  import qsim_pkg::*;

  localparam int          IN_DEPTH   = 32;
  localparam int          GATE_DEPTH = 1024;
  localparam int          WAIT_LIMIT = 50;
  localparam int          RUN_LIMIT  = 5000;
  // 1.0 + 0.0i in Q16.16
  localparam logic [63:0] ONE        = 64'h0001_0000_0000_0000;

  logic                  clk;
  logic                  reset_n;
  logic                  dut_valid;
  logic                  dut_ready;
  logic [MEM_ADDR_W-1:0] in_read_address;
  logic [MEM_DATA_W-1:0] in_read_data = '0;
  logic [MEM_ADDR_W-1:0] gate_read_address;
  logic [MEM_DATA_W-1:0] gate_read_data = '0;
  logic                  out_write_enable;
  logic [MEM_ADDR_W-1:0] out_write_address;
  logic [MEM_DATA_W-1:0] out_write_data;

  logic [MEM_DATA_W-1:0] in_mem   [IN_DEPTH];
  logic [MEM_DATA_W-1:0] gate_mem [GATE_DEPTH];
  logic [MEM_DATA_W-1:0] out_mem  [MAX_STATES];
  logic [MEM_DATA_W-1:0] expected [MAX_STATES];
  int                    write_hits [MAX_STATES];
  int                    write_count = 0;
  int                    run_q = 0;

  tb_clock u_clock (
    .clk     (clk),
    .reset_n (reset_n)
  );

  qsim_top dut (
    .clk               (clk),
    .reset_n           (reset_n),
    .dut_valid         (dut_valid),
    .dut_ready         (dut_ready),
    .in_read_address   (in_read_address),
    .in_read_data      (in_read_data),
    .gate_read_address (gate_read_address),
    .gate_read_data    (gate_read_data),
    .out_write_enable  (out_write_enable),
    .out_write_address (out_write_address),
    .out_write_data    (out_write_data)
  );

  // Input and gate memories with one cycle read latency
  always @(posedge clk) begin
    in_read_data   <= in_mem[in_read_address];
    gate_read_data <= gate_mem[gate_read_address];
  end

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("Done: errors found");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic abort_run(input string reason);
    $display("Failure at %0t: %s", $time, reason);
    $display("Done: errors found");
    $fatal(1, "run aborted");
  endtask

  // ----------------------------------------
  // Output memory and compare process
  // ----------------------------------------
  always @(posedge clk) begin
    // Accepted start clears the write record
    if (dut_valid && dut_ready) begin
      write_count = 0;
      for (int k = 0; k < MAX_STATES; k++) begin
        write_hits[k] = 0;
      end
    end
    if (out_write_enable) begin
      write_count++;
      if (int'(out_write_address) >= run_q) begin
        abort_run($sformatf("write to address %0d outside a vector of %0d words",
                            out_write_address, run_q));
      end else begin
        write_hits[out_write_address[MAX_QUBITS-1:0]]++;
        out_mem[out_write_address[MAX_QUBITS-1:0]] = out_write_data;
        check_value($sformatf("output word %0d", out_write_address), out_write_data,
                    expected[out_write_address[MAX_QUBITS-1:0]]);
      end
    end
  end

  // Signed Q16.16 product shifted arithmetically and truncated to 32 bits
  function automatic logic [31:0] q16_product(input logic [31:0] a, input logic [31:0] b);
    longint p;
    p = longint'($signed(a)) * longint'($signed(b));
    return 32'(p >>> 16);
  endfunction

  // Reference model applying all m gates to the loaded vector
  function automatic void compute_expected(input int q, input int m);
    logic [31:0] cur_re [MAX_STATES];
    logic [31:0] cur_im [MAX_STATES];
    logic [31:0] nxt_re [MAX_STATES];
    logic [31:0] nxt_im [MAX_STATES];
    logic [63:0] g;
    for (int k = 0; k < q; k++) begin
      cur_re[k] = in_mem[k + 1][63:32];
      cur_im[k] = in_mem[k + 1][31:0];
    end
    for (int n = 0; n < m; n++) begin
      for (int i = 0; i < q; i++) begin
        nxt_re[i] = '0;
        nxt_im[i] = '0;
        for (int j = 0; j < q; j++) begin
          g = gate_mem[n * q * q + i * q + j];
          nxt_re[i] = nxt_re[i] + q16_product(g[63:32], cur_re[j])
                      - q16_product(g[31:0], cur_im[j]);
          nxt_im[i] = nxt_im[i] + q16_product(g[63:32], cur_im[j])
                      + q16_product(g[31:0], cur_re[j]);
        end
      end
      for (int k = 0; k < q; k++) begin
        cur_re[k] = nxt_re[k];
        cur_im[k] = nxt_im[k];
      end
    end
    for (int k = 0; k < q; k++) begin
      expected[k] = {cur_re[k], cur_im[k]};
    end
  endfunction

  // Each part in [-1.0, 1.0]
  function automatic logic [63:0] random_sample();
    logic [31:0] re;
    logic [31:0] im;
    re = 32'($urandom_range(32'h20000)) - 32'h10000;
    im = 32'($urandom_range(32'h20000)) - 32'h10000;
    return {re, im};
  endfunction

  task automatic clear_memories();
    for (int a = 0; a < IN_DEPTH; a++) begin
      in_mem[a] = '0;
    end
    for (int a = 0; a < GATE_DEPTH; a++) begin
      gate_mem[a] = '0;
    end
  endtask

  task automatic load_case(input int qubits, input int m, input bit random_gates);
    int q;
    q = 1 << qubits;
    clear_memories();
    in_mem[0] = {32'(qubits), 32'(m)};
    for (int k = 0; k < q; k++) begin
      in_mem[k + 1] = random_sample();
    end
    if (random_gates) begin
      for (int a = 0; a < m * q * q; a++) begin
        gate_mem[a] = random_sample();
      end
    end
  endtask

  // ----------------------------------------
  // Handshake and run control
  // ----------------------------------------
  task automatic check_reset_behavior();
    int cycles;
    cycles = 0;
    @(posedge clk);
    #1;
    while (!reset_n) begin
      check_value("dut_ready in reset", 64'(dut_ready), 64'd0);
      check_value("out_write_enable in reset", 64'(out_write_enable), 64'd0);
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > WAIT_LIMIT) abort_run("reset was never released");
    end
    cycles = 0;
    while (!dut_ready) begin
      check_value("out_write_enable after reset", 64'(out_write_enable), 64'd0);
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > WAIT_LIMIT) abort_run("dut_ready did not rise after reset");
    end
    check_value("out_write_enable when ready", 64'(out_write_enable), 64'd0);
  endtask

  task automatic run_case(input int q, input int m, input bit hold_valid);
    int cycles;
    run_q = q;
    compute_expected(q, m);
    dut_valid = 1'b1;
    cycles = 0;
    while (!dut_ready) begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > WAIT_LIMIT) abort_run("dut_ready stayed low before a start");
    end
    // Next edge takes the handshake
    @(posedge clk);
    #1;
    if (!hold_valid) dut_valid = 1'b0;
    cycles = 0;
    while (!dut_ready) begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > RUN_LIMIT) abort_run("run did not finish within the cycle limit");
    end
    dut_valid = 1'b0;
    check_value("write count", 64'(write_count), 64'(q));
    for (int k = 0; k < q; k++) begin
      check_value($sformatf("writes to address %0d", k), 64'(write_hits[k]), 64'd1);
    end
  endtask

  task automatic compare_with_input(input int q);
    for (int k = 0; k < q; k++) begin
      check_value($sformatf("unchanged amplitude %0d", k), out_mem[k], in_mem[k + 1]);
    end
  endtask

  initial begin
    void'($urandom(32'h25d04142));
    dut_valid = 1'b0;
    clear_memories();
    check_reset_behavior();

    // One qubit through an identity gate
    load_case(1, 1, 1'b0);
    gate_mem[0] = ONE;
    gate_mem[3] = ONE;
    run_case(2, 1, 1'b0);
    compare_with_input(2);

    // Empty gate list
    load_case(2, 0, 1'b0);
    run_case(4, 0, 1'b0);
    compare_with_input(4);

    // Random runs started as soon as ready returns
    for (int qubits = 1; qubits <= MAX_QUBITS; qubits++) begin
      for (int rep = 0; rep < 2; rep++) begin
        load_case(qubits, int'($urandom_range(3, 1)), 1'b1);
        run_case(1 << qubits, int'(in_mem[0][31:0]), 1'b0);
      end
    end

    // Valid kept high for the whole run
    load_case(3, 2, 1'b1);
    run_case(8, 2, 1'b1);
    load_case(2, 1, 1'b1);
    run_case(4, 1, 1'b1);

    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/tb_clock.sv */
`default_nettype none
`timescale 1ns/100ps

module tb_clock (
  output logic clk,
  output logic reset_n
);

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Reset low for two rising edges, released just after the second
  initial begin
    reset_n = 1'b0;
    repeat (2) @(posedge clk);
    #1 reset_n = 1'b1;
  end

endmodule

`default_nettype wire

/* rtl/qsim_top.sv */
`default_nettype none
`timescale 1ns/100ps

module qsim_top (
  input  logic                            clk,
  input  logic                            reset_n,
  input  logic                            dut_valid,
  output logic                            dut_ready,
  output logic [qsim_pkg::MEM_ADDR_W-1:0] in_read_address,
  input  logic [qsim_pkg::MEM_DATA_W-1:0] in_read_data,
  output logic [qsim_pkg::MEM_ADDR_W-1:0] gate_read_address,
  input  logic [qsim_pkg::MEM_DATA_W-1:0] gate_read_data,
  output logic                            out_write_enable,
  output logic [qsim_pkg::MEM_ADDR_W-1:0] out_write_address,
  output logic [qsim_pkg::MEM_DATA_W-1:0] out_write_data
);

  import qsim_pkg::*;

  phase_t           phase;
  logic             load_last;
  logic             row_start;
  logic             row_last;
  logic             gate_last;
  logic             compute_last;
  logic             write_last;
  logic [IDX_W-1:0] col_index;
  logic [IDX_W-1:0] row_index;
  logic [IDX_W-1:0] load_index;
  sample_t          amplitude;
  logic             result_valid;
  sample_t          result;

  // Input data trails its address by one cycle
  always_ff @(posedge clk) begin
    load_index <= col_index;
  end

  qsim_ctrl u_ctrl (
    .clk          (clk),
    .reset_n      (reset_n),
    .dut_valid    (dut_valid),
    .load_last    (load_last),
    .gate_last    (gate_last),
    .compute_last (compute_last),
    .write_last   (write_last),
    .phase        (phase),
    .dut_ready    (dut_ready)
  );

  qsim_index_counter u_counter (
    .clk               (clk),
    .reset_n           (reset_n),
    .phase             (phase),
    .in_read_data      (in_read_data),
    .in_read_address   (in_read_address),
    .gate_read_address (gate_read_address),
    .out_write_address (out_write_address),
    .out_write_enable  (out_write_enable),
    .col_index         (col_index),
    .row_index         (row_index),
    .load_last         (load_last),
    .row_start         (row_start),
    .row_last          (row_last),
    .gate_last         (gate_last),
    .compute_last      (compute_last),
    .write_last        (write_last)
  );

  qsim_state_buffer u_buffer (
    .clk            (clk),
    .phase          (phase),
    .in_read_data   (in_read_data),
    .load_index     (load_index),
    .col_index      (col_index),
    .row_index      (row_index),
    .result_valid   (result_valid),
    .result         (result),
    .gate_last      (gate_last),
    .amplitude      (amplitude),
    .out_write_data (out_write_data)
  );

  qsim_cmac u_cmac (
    .clk          (clk),
    .reset_n      (reset_n),
    .gate_word    (gate_read_data),
    .amplitude    (amplitude),
    .row_start    (row_start),
    .row_last     (row_last),
    .result_valid (result_valid),
    .result       (result)
  );

endmodule

`default_nettype wire

/* rtl/qsim_cmac.sv */
`default_nettype none
`timescale 1ns/100ps

module qsim_cmac (
  input  logic              clk,
  input  logic              reset_n,
  input  qsim_pkg::sample_t gate_word,
  input  qsim_pkg::sample_t amplitude,
  input  logic              row_start,
  input  logic              row_last,
  output logic              result_valid,
  output qsim_pkg::sample_t result
);

  import qsim_pkg::*;

  sample_t           gate_q;
  sample_t           amp_q;
  logic              start_q;
  logic              last_q;
  logic [PART_W-1:0] base_re;
  logic [PART_W-1:0] base_im;

  // Full signed product scaled back to Q16.16
  function automatic logic [PART_W-1:0] fx_mul(input logic [PART_W-1:0] a,
                                                input logic [PART_W-1:0] b);
    logic signed [2*PART_W-1:0] full;
    full = $signed(a) * $signed(b);
    return full[FRAC_BITS +: PART_W];
  endfunction

  // Operand stage
  always_ff @(posedge clk) begin
    gate_q <= gate_word;
    amp_q  <= amplitude;
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      start_q      <= 1'b0;
      last_q       <= 1'b0;
      result_valid <= 1'b0;
    end else begin
      start_q      <= row_start;
      last_q       <= row_last;
      result_valid <= last_q;
    end
  end

  // New row restarts the sum
  assign base_re = start_q ? '0 : result.re;
  assign base_im = start_q ? '0 : result.im;

  // Accumulate stage, wraps in PART_W bits
  always_ff @(posedge clk) begin
    result.re <= base_re + fx_mul(gate_q.re, amp_q.re) - fx_mul(gate_q.im, amp_q.im);
    result.im <= base_im + fx_mul(gate_q.re, amp_q.im) + fx_mul(gate_q.im, amp_q.re);
  end

endmodule

`default_nettype wire

/* rtl/qsim_state_buffer.sv */
`default_nettype none
`timescale 1ns/100ps

module qsim_state_buffer (
  input  logic                            clk,
  input  qsim_pkg::phase_t                phase,
  input  qsim_pkg::mem_word_u             in_read_data,
  input  logic [qsim_pkg::IDX_W-1:0]      load_index,
  input  logic [qsim_pkg::IDX_W-1:0]      col_index,
  input  logic [qsim_pkg::IDX_W-1:0]      row_index,
  input  logic                            result_valid,
  input  qsim_pkg::sample_t               result,
  input  logic                            gate_last,
  output qsim_pkg::sample_t               amplitude,
  output logic [qsim_pkg::MEM_DATA_W-1:0] out_write_data
);

  import qsim_pkg::*;

  sample_t          cur_vec  [MAX_STATES];
  sample_t          next_vec [MAX_STATES];
  // Row number follows its sum through address, operand and accumulate stages
  logic [IDX_W-1:0] row_pipe [3];

  always_ff @(posedge clk) begin
    row_pipe[0] <= row_index;
    row_pipe[1] <= row_pipe[0];
    row_pipe[2] <= row_pipe[1];
  end

  // Registered read so the amplitude meets the gate word from memory
  always_ff @(posedge clk) begin
    amplitude <= cur_vec[col_index[MAX_QUBITS-1:0]];
  end

  // ----------------------------------------
  // Vector updates
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (phase == load_state) begin
      // Both copies start from the input so an empty gate list keeps it
      cur_vec[load_index[MAX_QUBITS-1:0]]  <= in_read_data.sample;
      next_vec[load_index[MAX_QUBITS-1:0]] <= in_read_data.sample;
    end else begin
      if (result_valid) begin
        next_vec[row_pipe[2][MAX_QUBITS-1:0]] <= result;
      end
      if (gate_last) begin
        cur_vec <= next_vec;
      end
    end
  end

  assign out_write_data = {amplitude.re, amplitude.im};

endmodule

`default_nettype wire

/* rtl/qsim_index_counter.sv */
`default_nettype none
`timescale 1ns/100ps

module qsim_index_counter (
  input  logic                                clk,
  input  logic                                reset_n,
  input  qsim_pkg::phase_t                    phase,
  input  qsim_pkg::mem_word_u                 in_read_data,
  output logic [qsim_pkg::MEM_ADDR_W-1:0]     in_read_address,
  output logic [qsim_pkg::MEM_ADDR_W-1:0]     gate_read_address,
  output logic [qsim_pkg::MEM_ADDR_W-1:0]     out_write_address,
  output logic                                out_write_enable,
  output logic [qsim_pkg::IDX_W-1:0]          col_index,
  output logic [qsim_pkg::IDX_W-1:0]          row_index,
  output logic                                load_last,
  output logic                                row_start,
  output logic                                row_last,
  output logic                                gate_last,
  output logic                                compute_last,
  output logic                                write_last
);

  import qsim_pkg::*;

  logic [IDX_W-1:0]  q_size;
  logic [IDX_W-1:0]  q_size_in;
  logic [IDX_W-1:0]  q_last;
  logic [GATE_W-1:0] m_count;
  logic [GATE_W-1:0] gate_count;
  logic              draining;
  logic [1:0]        drain_count;
  logic              issuing;
  logic              col_wrap;
  logic              row_wrap;

  // Q = 2^qubits, capped at the largest supported vector
  always_comb begin
    if (in_read_data.hdr.qubits > MAX_QUBITS) begin
      q_size_in = IDX_W'(MAX_STATES);
    end else begin
      q_size_in = IDX_W'(1) << in_read_data.hdr.qubits;
    end
  end

  assign q_last   = q_size - 1'b1;
  assign col_wrap = (col_index == q_last);
  assign row_wrap = (row_index == q_last);
  assign issuing  = (phase == compute) && !draining && (m_count != '0);

  // ----------------------------------------
  // Phase end flags
  // ----------------------------------------
  assign load_last    = (phase == load_state) && (col_index == q_size);
  // Pipeline drained and last row written, or nothing to apply
  assign gate_last    = (draining && (drain_count == 2'd3)) ||
                        ((phase == compute) && (m_count == '0));
  assign compute_last = (phase == compute) &&
                        ((m_count == '0) || (gate_count == m_count - 1'b1));
  assign write_last   = (phase == write_out) && col_wrap;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      in_read_address   <= '0;
      gate_read_address <= '0;
      out_write_address <= '0;
      out_write_enable  <= 1'b0;
      col_index         <= '0;
      row_index         <= '0;
      row_start         <= 1'b0;
      row_last          <= 1'b0;
      q_size            <= '0;
      m_count           <= '0;
      gate_count        <= '0;
      draining          <= 1'b0;
      drain_count       <= '0;
    end else begin
      // Row flags line up with the gate data, one cycle after the address
      row_start        <= issuing && (col_index == '0);
      row_last         <= issuing && col_wrap;
      out_write_enable <= (phase == write_out);
      case (phase)
        idle: begin
          in_read_address   <= '0;
          gate_read_address <= '0;
          col_index         <= '0;
          row_index         <= '0;
          gate_count        <= '0;
          draining          <= 1'b0;
          drain_count       <= '0;
        end
        read_header: begin
          q_size          <= q_size_in;
          m_count         <= in_read_data.hdr.gates[GATE_W-1:0];
          in_read_address <= MEM_ADDR_W'(1);
          col_index       <= '0;
        end
        load_state: begin
          in_read_address <= in_read_address + 1'b1;
          col_index       <= load_last ? '0 : col_index + 1'b1;
        end
        compute: begin
          if (issuing) begin
            // Gate entries are stored in exactly the order they are used
            gate_read_address <= gate_read_address + 1'b1;
            col_index         <= col_wrap ? '0 : col_index + 1'b1;
            if (col_wrap) begin
              row_index <= row_wrap ? '0 : row_index + 1'b1;
              draining  <= row_wrap;
            end
          end else if (draining) begin
            drain_count <= drain_count + 1'b1;
            if (gate_last) begin
              draining   <= 1'b0;
              gate_count <= gate_count + 1'b1;
            end
          end
        end
        write_out: begin
          out_write_address <= MEM_ADDR_W'(col_index);
          col_index         <= col_index + 1'b1;
        end
        default: begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/qsim_ctrl.sv */
`default_nettype none
`timescale 1ns/100ps

module qsim_ctrl (
  input  logic             clk,
  input  logic             reset_n,
  input  logic             dut_valid,
  input  logic             load_last,
  input  logic             gate_last,
  input  logic             compute_last,
  input  logic             write_last,
  output qsim_pkg::phase_t phase,
  output logic             dut_ready
);

  import qsim_pkg::*;

  phase_t phase_next;
  logic   start;
  logic   header_wait;

  // Handshake accepted only while ready is shown
  assign start = dut_valid && dut_ready;

  // ----------------------------------------
  // Next phase
  // ----------------------------------------
  always_comb begin
    phase_next = phase;
    case (phase)
      idle: begin
        if (start) begin
          phase_next = read_header;
        end
      end
      read_header: begin
        // Header word needs two cycles to come back
        if (header_wait) begin
          phase_next = load_state;
        end
      end
      load_state: begin
        if (load_last) begin
          phase_next = compute;
        end
      end
      compute: begin
        // Leave once the final gate has been folded back
        if (gate_last && compute_last) begin
          phase_next = write_out;
        end
      end
      write_out: begin
        if (write_last) begin
          phase_next = finish;
        end
      end
      finish: begin
        phase_next = idle;
      end
      default: begin
        phase_next = idle;
      end
    endcase
  end

  // ----------------------------------------
  // Phase and ready registers
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      phase       <= idle;
      header_wait <= 1'b0;
      dut_ready   <= 1'b0;
    end else begin
      phase       <= phase_next;
      header_wait <= (phase == read_header) && !header_wait;
      // Drop at the accepting edge, rise again after the last write
      dut_ready   <= ((phase == idle) && !start) || (phase == finish);
    end
  end

endmodule

`default_nettype wire

/* rtl/qsim_pkg.sv */
`default_nettype none

package qsim_pkg;

  // ----------------------------------------
  // Widths and limits
  // ----------------------------------------
  localparam int MEM_DATA_W = 64;
  localparam int MEM_ADDR_W = 16;
  localparam int PART_W     = 32;
  localparam int FRAC_BITS  = 16;
  localparam int MAX_QUBITS = 4;
  localparam int MAX_STATES = 16;
  localparam int IDX_W      = 5;
  localparam int GATE_W     = 16;

  // Complex amplitude in Q16.16, real part in the upper half
  typedef struct packed {
    logic [PART_W-1:0] re;
    logic [PART_W-1:0] im;
  } sample_t;

  // Word at input address 0
  typedef struct packed {
    logic [MEM_DATA_W/2-1:0] qubits;
    logic [MEM_DATA_W/2-1:0] gates;
  } header_t;

  // Same input word seen as header or as amplitude
  typedef union packed {
    header_t hdr;
    sample_t sample;
  } mem_word_u;

  // Run phases
  typedef enum logic [2:0] {
    idle,
    read_header,
    load_state,
    compute,
    write_out,
    finish
  } phase_t;

endpackage

`default_nettype wire
